//--- common/rv_isa_pkg.sv
package rv_isa_pkg;

    // base integer word and register index widths.
    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;

    // shifts use only the low bits of operand b.
    localparam int SHAMT_W = 5;

    typedef logic [XLEN-1:0] word_t;

    // register 0 is hardwired to zero wherever this index is consumed.
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // operation codes carried with each decoded instruction.
    typedef enum logic [3:0]
    {
        ADD    = 4'd0,
        SUB    = 4'd1,
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        SLL    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        SLT    = 4'd8,
        SLTU   = 4'd9,
        // moves operand b to the result, used for immediate loads.
        PASS_B = 4'd10
    } alu_op_e;

endpackage

//--- common/rv_pipe_pkg.sv
package rv_pipe_pkg;

    // registered stages between issue sampling and the retire outputs.
    localparam int PIPE_DEPTH = 3;

    // where an E-stage operand is taken from.
    typedef enum logic [1:0]
    {
        // value read from the register file at issue.
        FWD_REG    = 2'd0,
        // result held in the M stage.
        FWD_ALU2   = 2'd1,
        // result presented in the W stage.
        FWD_WRITE  = 2'd2,
        // copy of the write made at the previous edge.
        FWD_WRBACK = 2'd3
    } fwd_src_e;

endpackage

//--- design/rv_operand_fetch.sv
`timescale 1ns/1ns

module rv_operand_fetch
#(
    parameter int REG_COUNT = 32
)
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_valid,
    input  rv_isa_pkg::alu_op_e   i_op,
    input  rv_isa_pkg::reg_addr_t i_rs1,
    input  rv_isa_pkg::reg_addr_t i_rs2,
    input  rv_isa_pkg::reg_addr_t i_rd,
    input  rv_isa_pkg::word_t     i_imm,
    input  logic                  i_use_imm,
    input  logic                  i_wr_en,
    input  rv_isa_pkg::reg_addr_t i_wr_rd,
    input  rv_isa_pkg::word_t     i_wr_data,
    output logic                  o_valid,
    output rv_isa_pkg::alu_op_e   o_op,
    output rv_isa_pkg::reg_addr_t o_rs1,
    output rv_isa_pkg::reg_addr_t o_rs2,
    output rv_isa_pkg::reg_addr_t o_rd,
    output rv_isa_pkg::word_t     o_imm,
    output logic                  o_use_imm,
    output rv_isa_pkg::word_t     o_reg_data1,
    output rv_isa_pkg::word_t     o_reg_data2
);

    import rv_isa_pkg::*;

    // a 16-entry build drops the top index bit.
    localparam int IDX_W = $clog2(REG_COUNT);

    word_t            regs [REG_COUNT];
    logic [IDX_W-1:0] rd_idx1;
    logic [IDX_W-1:0] rd_idx2;
    logic [IDX_W-1:0] wr_idx;

    assign rd_idx1 = i_rs1[IDX_W-1:0];
    assign rd_idx2 = i_rs2[IDX_W-1:0];
    assign wr_idx  = i_wr_rd[IDX_W-1:0];

    // writes to register 0 are dropped, so it keeps its reset value of zero.
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_wr_en && (wr_idx != '0))
        begin
            regs[wr_idx] <= i_wr_data;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            o_valid <= 1'b0;
            o_rs1   <= '0;
            o_rs2   <= '0;
            o_rd    <= '0;
        end
        else
        begin
            o_valid <= i_valid;
            o_rs1   <= i_rs1;
            o_rs2   <= i_rs2;
            o_rd    <= i_rd;
        end
    end

    // the read sees the old value when the same register is written at this edge.
    always_ff @(posedge i_clk)
    begin
        o_op        <= i_op;
        o_imm       <= i_imm;
        o_use_imm   <= i_use_imm;
        o_reg_data1 <= regs[rd_idx1];
        o_reg_data2 <= regs[rd_idx2];
    end

endmodule

//--- design/rv_hazard.sv
`timescale 1ns/1ns

module rv_hazard
#(
    parameter bit ALU2_FWD_EN = 1'b1
)
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  rv_isa_pkg::reg_addr_t i_rs1,
    input  rv_isa_pkg::reg_addr_t i_rs2,
    input  rv_isa_pkg::reg_addr_t i_alu2_rd,
    input  logic                  i_alu2_reg_write,
    input  rv_isa_pkg::reg_addr_t i_write_rd,
    input  logic                  i_write_reg_write,
    input  rv_isa_pkg::word_t     i_reg_data1,
    input  rv_isa_pkg::word_t     i_reg_data2,
    input  rv_isa_pkg::word_t     i_alu2_data,
    input  rv_isa_pkg::word_t     i_wr_data,
    output rv_isa_pkg::word_t     o_data1,
    output rv_isa_pkg::word_t     o_data2
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic      wrback_valid;
    reg_addr_t wrback_rd;
    word_t     wrback_data;
    fwd_src_e  src1_sel;
    fwd_src_e  src2_sel;

    // the register file was read one edge before this write landed, so keep a copy.
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            wrback_valid <= 1'b0;
            wrback_rd    <= '0;
            wrback_data  <= '0;
        end
        else
        begin
            wrback_valid <= i_write_reg_write;
            wrback_rd    <= i_write_rd;
            wrback_data  <= i_wr_data;
        end
    end

    function automatic logic dest_hit(reg_addr_t rs, logic dest_valid, reg_addr_t dest_rd);
        return dest_valid && (dest_rd != '0) && (dest_rd == rs);
    endfunction

    // the youngest producer wins and register 0 is never forwarded.
    function automatic fwd_src_e pick_src(reg_addr_t rs);
        fwd_src_e sel;
        sel = FWD_REG;
        if (rs == '0)
            sel = FWD_REG;
        else if (ALU2_FWD_EN && dest_hit(rs, i_alu2_reg_write, i_alu2_rd))
            sel = FWD_ALU2;
        else if (dest_hit(rs, i_write_reg_write, i_write_rd))
            sel = FWD_WRITE;
        else if (dest_hit(rs, wrback_valid, wrback_rd))
            sel = FWD_WRBACK;
        return sel;
    endfunction

    function automatic word_t pick_data(fwd_src_e sel, word_t reg_data);
        case (sel)
            FWD_ALU2:   return i_alu2_data;
            FWD_WRITE:  return i_wr_data;
            FWD_WRBACK: return wrback_data;
            default:    return reg_data;
        endcase
    endfunction

    always_comb
    begin
        src1_sel = pick_src(i_rs1);
        src2_sel = pick_src(i_rs2);
        o_data1  = pick_data(src1_sel, i_reg_data1);
        o_data2  = pick_data(src2_sel, i_reg_data2);
    end

endmodule

//--- design/rv_alu.sv
`timescale 1ns/1ns

module rv_alu
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_valid,
    input  rv_isa_pkg::alu_op_e   i_op,
    input  rv_isa_pkg::reg_addr_t i_rd,
    input  rv_isa_pkg::word_t     i_imm,
    input  logic                  i_use_imm,
    input  rv_isa_pkg::word_t     i_data1,
    input  rv_isa_pkg::word_t     i_data2,
    output logic                  o_valid,
    output rv_isa_pkg::reg_addr_t o_rd,
    output rv_isa_pkg::word_t     o_data
);

    import rv_isa_pkg::*;

    word_t              op_b;
    word_t              result;
    logic [SHAMT_W-1:0] shamt;

    assign op_b  = i_use_imm ? i_imm : i_data2;
    assign shamt = op_b[SHAMT_W-1:0];

    always_comb
    begin
        case (i_op)
            ADD:     result = i_data1 + op_b;
            SUB:     result = i_data1 - op_b;
            AND:     result = i_data1 & op_b;
            OR:      result = i_data1 | op_b;
            XOR:     result = i_data1 ^ op_b;
            SLL:     result = i_data1 << shamt;
            SRL:     result = i_data1 >> shamt;
            SRA:     result = word_t'($signed(i_data1) >>> shamt);
            SLT:     result = {{(XLEN-1){1'b0}}, $signed(i_data1) < $signed(op_b)};
            SLTU:    result = {{(XLEN-1){1'b0}}, i_data1 < op_b};
            PASS_B:  result = op_b;
            default: result = '0;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            o_valid <= 1'b0;
            o_rd    <= '0;
        end
        else
        begin
            o_valid <= i_valid;
            o_rd    <= i_rd;
        end
    end

    always_ff @(posedge i_clk)
    begin
        o_data <= result;
    end

endmodule

//--- design/rv_retire.sv
`timescale 1ns/1ns

module rv_retire
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_valid,
    input  rv_isa_pkg::reg_addr_t i_rd,
    input  rv_isa_pkg::word_t     i_data,
    output logic                  o_valid,
    output rv_isa_pkg::reg_addr_t o_rd,
    output rv_isa_pkg::word_t     o_data
);

    // the W stage drives both the register file write port and the result ports.
    // a valid result aimed at register 0 is still presented here.
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            o_valid <= 1'b0;
            o_rd    <= '0;
        end
        else
        begin
            o_valid <= i_valid;
            o_rd    <= i_rd;
        end
    end

    always_ff @(posedge i_clk)
    begin
        o_data <= i_data;
    end

endmodule

//--- design/rv_exec_core.sv
`timescale 1ns/1ns

module rv_exec_core
#(
    parameter int REG_COUNT   = 32,
    parameter bit ALU2_FWD_EN = 1'b1
)
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_valid,
    input  rv_isa_pkg::alu_op_e   i_op,
    input  rv_isa_pkg::reg_addr_t i_rs1,
    input  rv_isa_pkg::reg_addr_t i_rs2,
    input  rv_isa_pkg::reg_addr_t i_rd,
    input  rv_isa_pkg::word_t     i_imm,
    input  logic                  i_use_imm,
    output logic                  o_wb_valid,
    output rv_isa_pkg::reg_addr_t o_wb_rd,
    output rv_isa_pkg::word_t     o_wb_data
);

    import rv_isa_pkg::*;

    logic      e_valid;
    alu_op_e   e_op;
    reg_addr_t e_rs1;
    reg_addr_t e_rs2;
    reg_addr_t e_rd;
    word_t     e_imm;
    logic      e_use_imm;
    word_t     e_reg_data1;
    word_t     e_reg_data2;
    word_t     fwd_data1;
    word_t     fwd_data2;
    logic      m_valid;
    reg_addr_t m_rd;
    word_t     m_data;
    logic      w_valid;
    reg_addr_t w_rd;
    word_t     w_data;

    rv_operand_fetch
    #(
        .REG_COUNT   (REG_COUNT)
    )
    u_fetch
    (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_valid     (i_valid),
        .i_op        (i_op),
        .i_rs1       (i_rs1),
        .i_rs2       (i_rs2),
        .i_rd        (i_rd),
        .i_imm       (i_imm),
        .i_use_imm   (i_use_imm),
        .i_wr_en     (w_valid),
        .i_wr_rd     (w_rd),
        .i_wr_data   (w_data),
        .o_valid     (e_valid),
        .o_op        (e_op),
        .o_rs1       (e_rs1),
        .o_rs2       (e_rs2),
        .o_rd        (e_rd),
        .o_imm       (e_imm),
        .o_use_imm   (e_use_imm),
        .o_reg_data1 (e_reg_data1),
        .o_reg_data2 (e_reg_data2)
    );

    rv_hazard
    #(
        .ALU2_FWD_EN       (ALU2_FWD_EN)
    )
    u_hazard
    (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_rs1             (e_rs1),
        .i_rs2             (e_rs2),
        .i_alu2_rd         (m_rd),
        .i_alu2_reg_write  (m_valid),
        .i_write_rd        (w_rd),
        .i_write_reg_write (w_valid),
        .i_reg_data1       (e_reg_data1),
        .i_reg_data2       (e_reg_data2),
        .i_alu2_data       (m_data),
        .i_wr_data         (w_data),
        .o_data1           (fwd_data1),
        .o_data2           (fwd_data2)
    );

    rv_alu u_alu
    (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_valid   (e_valid),
        .i_op      (e_op),
        .i_rd      (e_rd),
        .i_imm     (e_imm),
        .i_use_imm (e_use_imm),
        .i_data1   (fwd_data1),
        .i_data2   (fwd_data2),
        .o_valid   (m_valid),
        .o_rd      (m_rd),
        .o_data    (m_data)
    );

    rv_retire u_retire
    (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (m_valid),
        .i_rd    (m_rd),
        .i_data  (m_data),
        .o_valid (w_valid),
        .o_rd    (w_rd),
        .o_data  (w_data)
    );

    assign o_wb_valid = w_valid;
    assign o_wb_rd    = w_rd;
    assign o_wb_data  = w_data;

endmodule

//--- tb/rv_hazard_properties.sv
`timescale 1ns/1ns

module rv_hazard_properties
#(
    parameter bit ALU2_FWD_EN = 1'b1
)
(
    input logic                  i_clk,
    input logic                  i_rst_n,
    input rv_isa_pkg::reg_addr_t i_rs1,
    input rv_isa_pkg::reg_addr_t i_rs2,
    input rv_pipe_pkg::fwd_src_e i_src1_sel,
    input rv_pipe_pkg::fwd_src_e i_src2_sel
);

    import rv_pipe_pkg::*;

    // each select decodes to one of the four operand sources.
    a_src1_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !$isunknown(i_src1_sel) && (i_src1_sel inside {FWD_REG, FWD_ALU2, FWD_WRITE, FWD_WRBACK}))
        else $error("src1_sel holds an illegal value");

    a_src2_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !$isunknown(i_src2_sel) && (i_src2_sel inside {FWD_REG, FWD_ALU2, FWD_WRITE, FWD_WRBACK}))
        else $error("src2_sel holds an illegal value");

    // register 0 always comes from the register file.
    a_src1_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_rs1 == '0) |-> (i_src1_sel == FWD_REG))
        else $error("rs1 is register 0 but src1_sel is not FWD_REG");

    a_src2_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_rs2 == '0) |-> (i_src2_sel == FWD_REG))
        else $error("rs2 is register 0 but src2_sel is not FWD_REG");

    a_no_alu2: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        ALU2_FWD_EN || ((i_src1_sel != FWD_ALU2) && (i_src2_sel != FWD_ALU2)))
        else $error("M stage forwarding selected while it is disabled");

endmodule

bind rv_hazard rv_hazard_properties
#(
    .ALU2_FWD_EN (ALU2_FWD_EN)
)
u_hazard_props
(
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_rs1      (i_rs1),
    .i_rs2      (i_rs2),
    .i_src1_sel (src1_sel),
    .i_src2_sel (src2_sel)
);

//--- tb/rv_exec_core_tb.sv
`timescale 1ns/1ns

module rv_exec_core_tb;

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    localparam int    MAX_SLOTS    = 64;
    localparam int    MAX_TESTS    = 16;
    localparam int    RESET_CYCLES = 16;
    localparam int    MARGIN       = 20;
    localparam int    REG_COUNT    = 32;
    localparam string GOLDEN_FILE  = "tb/rv_exec_golden.txt";

    // one issue slot from the golden file and the result it should retire.
    typedef struct packed
    {
        logic      valid;
        alu_op_e   op;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
        logic      use_imm;
        int        test;
        reg_addr_t exp_rd;
        word_t     exp_data;
    } slot_t;

    typedef struct packed
    {
        int        test;
        reg_addr_t rd;
        word_t     data;
    } expect_t;

    logic      i_clk;
    logic      i_rst_n;
    logic      i_valid;
    alu_op_e   i_op;
    reg_addr_t i_rs1;
    reg_addr_t i_rs2;
    reg_addr_t i_rd;
    word_t     i_imm;
    logic      i_use_imm;
    logic      o_wb_valid;
    reg_addr_t o_wb_rd;
    word_t     o_wb_data;

    slot_t     slots [MAX_SLOTS];
    expect_t   expect_q [$];
    word_t     reg_model [REG_COUNT];
    int        slot_count;
    int        readback_test;
    int        test_total [MAX_TESTS];
    int        test_done [MAX_TESTS];
    int        test_errors [MAX_TESTS];
    int        check_count;
    int        error_count;
    int        cycle_count;
    int        cycle_limit;
    int        seed = 32'h99cb06a6;
    bit        golden_ok;

    rv_exec_core
    #(
        .REG_COUNT   (REG_COUNT),
        .ALU2_FWD_EN (1'b1)
    )
    uut
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (i_valid),
        .i_op       (i_op),
        .i_rs1      (i_rs1),
        .i_rs2      (i_rs2),
        .i_rd       (i_rd),
        .i_imm      (i_imm),
        .i_use_imm  (i_use_imm),
        .o_wb_valid (o_wb_valid),
        .o_wb_rd    (o_wb_rd),
        .o_wb_data  (o_wb_data)
    );

    initial
    begin
        i_clk = 1'b0;
        forever
        begin
            #5 i_clk = ~i_clk;
        end
    end

    always @(posedge i_clk)
    begin
        cycle_count++;
        if ((cycle_limit != 0) && (cycle_count >= cycle_limit))
        begin
            $display("timeout after %0d cycles, %0d results never arrived",
                     cycle_count, expect_q.size());
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp,
                             input int test, output bit ok);
        check_count++;
        ok = (got === exp);
        if (!ok)
        begin
            $display("ERROR %s: got %h, expected %h (test %0d)", name, got, exp, test);
            error_count++;
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp,
                              input int test, output bit ok);
        check_count++;
        ok = (got === exp);
        if (!ok)
        begin
            $display("ERROR %s: got %h, expected %h (test %0d)", name, got, exp, test);
            error_count++;
        end
    endtask

    task automatic load_golden(output bit ok);
        int          fd;
        string       text;
        logic [31:0] f_valid;
        logic [31:0] f_op;
        logic [31:0] f_rs1;
        logic [31:0] f_rs2;
        logic [31:0] f_rd;
        logic [31:0] f_imm;
        logic [31:0] f_use;
        logic [31:0] f_test;
        logic [31:0] f_exp_rd;
        logic [31:0] f_exp_data;
        int          fields;
        int          max_test;
        slot_t       s;
        slot_count = 0;
        max_test   = 0;
        for (int t = 0; t < MAX_TESTS; t++)
        begin
            test_total[t]  = 0;
            test_done[t]   = 0;
            test_errors[t] = 0;
        end
        for (int r = 0; r < REG_COUNT; r++)
        begin
            reg_model[r] = '0;
        end
        fd = $fopen(GOLDEN_FILE, "r");
        ok = (fd != 0);
        if (ok)
        begin
            while (!$feof(fd) && (slot_count < MAX_SLOTS))
            begin
                text = "";
                void'($fgets(text, fd));
                fields = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h", f_valid, f_op, f_rs1,
                                 f_rs2, f_rd, f_imm, f_use, f_test, f_exp_rd, f_exp_data);
                if (fields == 10)
                begin
                    s.valid    = f_valid[0];
                    s.op       = alu_op_e'(f_op[3:0]);
                    s.rs1      = f_rs1[4:0];
                    s.rs2      = f_rs2[4:0];
                    s.rd       = f_rd[4:0];
                    s.imm      = f_imm;
                    s.use_imm  = f_use[0] | f_use[1];
                    s.test     = f_test;
                    s.exp_rd   = f_exp_rd[4:0];
                    s.exp_data = f_exp_data;
                    // a random immediate comes back unchanged through PASS_B.
                    if (f_use == 32'd2)
                    begin
                        s.imm      = $random(seed);
                        s.exp_data = s.imm;
                    end
                    if (s.valid)
                    begin
                        test_total[s.test]++;
                        // retired results land in the register file except for register 0.
                        if (s.exp_rd != '0)
                            reg_model[s.exp_rd] = s.exp_data;
                        if (s.test > max_test)
                            max_test = s.test;
                    end
                    slots[slot_count] = s;
                    slot_count++;
                end
            end
            $fclose(fd);
            readback_test = max_test + 1;
            ok = (slot_count > 0) && (readback_test < MAX_TESTS);
            if (ok)
                test_total[readback_test] = REG_COUNT;
        end
    endtask

    task automatic drive_slot(input slot_t s);
        expect_t e;
        i_valid   = s.valid;
        i_op      = s.op;
        i_rs1     = s.rs1;
        i_rs2     = s.rs2;
        i_rd      = s.rd;
        i_imm     = s.imm;
        i_use_imm = s.use_imm;
        if (s.valid)
        begin
            e.test = s.test;
            e.rd   = s.exp_rd;
            e.data = s.exp_data;
            expect_q.push_back(e);
        end
    endtask

    // adds register 0 to one register and retires the sum to rd 0, which writes nothing.
    task automatic drive_readback(input reg_addr_t r);
        expect_t e;
        i_valid   = 1'b1;
        i_op      = ADD;
        i_rs1     = r;
        i_rs2     = '0;
        i_rd      = '0;
        i_imm     = '0;
        i_use_imm = 1'b0;
        e.test    = readback_test;
        e.rd      = '0;
        e.data    = reg_model[r];
        expect_q.push_back(e);
    endtask

    task automatic drive_idle();
        i_valid   = 1'b0;
        i_op      = ADD;
        i_rs1     = '0;
        i_rs2     = '0;
        i_rd      = '0;
        i_imm     = '0;
        i_use_imm = 1'b0;
    endtask

    task automatic collect_result();
        expect_t e;
        bit      rd_ok;
        bit      data_ok;
        if (o_wb_valid)
        begin
            if (expect_q.size() == 0)
            begin
                $display("unexpected result for rd %0d while no instruction was pending",
                         o_wb_rd);
                error_count++;
            end
            else
            begin
                e = expect_q.pop_front();
                check_reg("o_wb_rd", o_wb_rd, e.rd, e.test, rd_ok);
                check_word("o_wb_data", o_wb_data, e.data, e.test, data_ok);
                if (!rd_ok || !data_ok)
                    test_errors[e.test]++;
                test_done[e.test]++;
                if (test_done[e.test] == test_total[e.test])
                begin
                    $display("test %0d finished: %0d results, %0d wrong",
                             e.test, test_total[e.test], test_errors[e.test]);
                end
            end
        end
    endtask

    initial
    begin
        i_rst_n     = 1'b0;
        check_count = 0;
        error_count = 0;
        cycle_count = 0;
        cycle_limit = 0;
        drive_idle();
        load_golden(golden_ok);
        cycle_limit = slot_count + REG_COUNT + PIPE_DEPTH + RESET_CYCLES + MARGIN;
        if (!golden_ok)
        begin
            $display("could not read usable stimulus from %s", GOLDEN_FILE);
            $display("SOME TESTS FAILED");
            $finish;
        end
        else
        begin
            repeat (RESET_CYCLES) @(negedge i_clk);
            i_rst_n = 1'b1;
            for (int n = 0; n < slot_count; n++)
            begin
                collect_result();
                drive_slot(slots[n]);
                @(negedge i_clk);
            end
            // reading every register back shows what bubbles and writes to register 0 left.
            for (int r = 0; r < REG_COUNT; r++)
            begin
                collect_result();
                drive_readback(reg_addr_t'(r));
                @(negedge i_clk);
            end
            drive_idle();
            while (expect_q.size() != 0)
            begin
                collect_result();
                @(negedge i_clk);
            end
            // extra cycles catch results that should never have been issued.
            repeat (PIPE_DEPTH)
            begin
                collect_result();
                @(negedge i_clk);
            end
            $display("%0d slots, %0d checks, %0d errors", slot_count, check_count, error_count);
            if (error_count == 0)
                $display("ALL TESTS PASSED");
            else
                $display("SOME TESTS FAILED");
            $finish;
        end
    end

endmodule

//--- tb/rv_exec_golden.txt
// valid op rs1 rs2 rd imm use_imm test exp_rd exp_data, all in hex, op codes as in rv_isa_pkg
// use_imm 2 loads a random immediate with PASS_B, and that immediate is the expected data
1 a 00 00 01 80000010 1 1 01 80000010
1 a 00 00 02 00000013 1 1 02 00000013
1 0 01 02 03 00000000 0 1 03 80000023
1 1 01 02 04 00000000 0 1 04 7ffffffd
1 2 01 02 05 00000000 0 1 05 00000010
1 3 01 02 06 00000000 0 1 06 80000013
1 4 01 02 07 00000000 0 1 07 80000003
1 5 01 02 08 00000000 0 1 08 00800000
1 6 01 02 09 00000000 0 1 09 00001000
1 7 01 02 0a 00000000 0 1 0a fffff000
1 8 01 02 0b 00000000 0 1 0b 00000001
1 9 02 00 0c 80000000 1 1 0c 00000001
1 a 00 00 0e 00000055 1 2 0e 00000055
1 0 0e 00 0f 00000001 1 2 0f 00000056
1 a 00 00 10 00000100 1 3 10 00000100
1 a 00 00 14 00000000 2 3 14 00000000
1 0 10 00 11 00000002 1 3 11 00000102
1 0 10 10 12 00000000 0 3 12 00000200
1 4 10 00 13 00000001 1 3 13 00000101
1 a 00 00 15 00000011 1 4 15 00000011
1 a 00 00 15 00000022 1 4 15 00000022
1 0 15 15 16 00000000 0 4 16 00000044
1 a 00 00 00 0000dead 1 5 00 0000dead
1 0 00 00 17 00000000 0 5 17 00000000
1 3 00 00 18 00000007 1 5 18 00000007
0 a 00 00 10 0000ffff 1 6 00 00000000
0 a 00 00 0e 0000ffff 1 6 00 00000000
1 0 10 0e 19 00000000 0 6 19 00000155

//--- tb.f
common/rv_isa_pkg.sv
common/rv_pipe_pkg.sv
design/rv_operand_fetch.sv
design/rv_hazard.sv
design/rv_alu.sv
design/rv_retire.sv
design/rv_exec_core.sv
tb/rv_hazard_properties.sv
tb/rv_exec_core_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP       = rv_exec_core_tb
FILELIST  = tb.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = SOME TESTS FAILED
PASS_MSG  = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a verdict"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
